/* project.f */
+incdir+src
src/divPkg.sv
src/divControl.sv
src/digitSelect.sv
src/otfConverter.sv
src/divIteration.sv
src/divResult.sv
src/divTop.sv
test/divTb.sv

/* run.sh */
#!/bin/sh
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module divTb \
  -f project.f --Mdir obj_dir -o divSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/divSim > sim.log 2>&1
simStatus=$?
cat sim.log

# The log decides the verdict
if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
exit 0

/* src/digitSelect.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module digitSelect (
  input  logic signed [`DIV_RW-1:0] residual4,
  input  logic        [`DIV_W-1:0]  divisor,
  output divPkg::digitT             digit
);

  // All values here share the divisor's LSB weight
  logic signed [`DIV_RW-1:0] w8;
  logic signed [`DIV_RW-1:0] d1;
  logic signed [`DIV_RW-1:0] d3;
  logic                      geP3;
  logic                      geP1;
  logic                      geM1;
  logic                      geM3;

  // D and 3D zero-extended to residual width
  assign d1 = $signed({{(`DIV_RW-`DIV_W){1'b0}}, divisor});
  assign d3 = d1 + (d1 <<< 1);

  // 8w with headroom for |w| up to 2D/3
  assign w8 = residual4 <<< 1;

  // Exact thresholds at +-D and +-3D
  assign geP3 = (w8 >= d3);
  assign geP1 = (w8 >= d1);
  assign geM1 = (w8 >= -d1);
  assign geM3 = (w8 >= -d3);

  //////////////////////////////
  // One-hot digit encoding
  //////////////////////////////

  always_comb begin
    digit.plus2  = geP3;
    digit.plus1  = geP1 & ~geP3;
    // Band between -D and +D gives digit 0
    digit.minus1 = geM3 & ~geM1;
    digit.minus2 = ~geM3;
  end

endmodule

/* src/divControl.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module divControl (
  input  logic          clk,
  input  logic          arstN,
  input  logic          start,
  input  divPkg::divOpT operands,
  output divPkg::divOpT opReg,
  output logic          busy,
  output divPkg::stepT  step,
  output logic          finish
);

  localparam int CntW = $clog2(`DIV_ITER + 1);

  logic [CntW-1:0] stepCnt;
  logic            accept;

  // Start only counts while idle
  assign accept = start & ~busy;

  // Operands stay put until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      opReg <= operands;
    end
  end

  //////////////////////////////
  // Step sequencing
  //////////////////////////////

  // Steps run while busy, except in the finish cycle
  always_comb begin
    step.active = busy & ~finish;
    step.first  = step.active & (stepCnt == '0);
    step.last   = step.active & (stepCnt == CntW'(`DIV_ITER - 1));
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy    <= 1'b0;
      finish  <= 1'b0;
      stepCnt <= '0;
    end else begin
      // Finish trails the last step by one cycle
      finish <= step.last;
      if (accept) begin
        busy    <= 1'b1;
        stepCnt <= '0;
      end else if (finish) begin
        busy <= 1'b0;
      end else if (step.active) begin
        stepCnt <= stepCnt + 1'b1;
      end
    end
  end

  // Accepted operands must be normalized
  assert property (@(posedge clk) disable iff (!arstN)
    accept |-> (operands.dividend[`DIV_W-1] & operands.divisor[`DIV_W-1]));

endmodule

/* src/divIteration.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module divIteration (
  input  logic                      clk,
  input  logic                      arstN,
  input  divPkg::stepT              step,
  input  divPkg::divOpT             opReg,
  output logic signed [`DIV_RW-1:0] residual,
  output logic [`DIV_QW-1:0]        u,
  output logic [`DIV_QW-1:0]        um
);

  // Mask starts with the top two quotient bits
  localparam logic [`DIV_QW-1:0] CInit = {2'b11, {(`DIV_QW-2){1'b0}}};

  logic signed [`DIV_RW-1:0] wCur;
  logic signed [`DIV_RW-1:0] dExt;
  logic signed [`DIV_RW-1:0] qd;
  logic signed [`DIV_RW-1:0] stepDiff;
  logic signed [`DIV_RW-1:0] resMag;
  logic signed [`DIV_RW-1:0] dBound;
  logic [`DIV_QW-1:0]        cReg;
  logic [`DIV_QW-1:0]        uCur;
  logic [`DIV_QW-1:0]        umCur;
  logic [`DIV_QW-1:0]        cCur;
  logic [`DIV_QW-1:0]        uNext;
  logic [`DIV_QW-1:0]        umNext;
  divPkg::digitT             digit;

  //////////////////////////////
  // Recurrence inputs
  //////////////////////////////

  // Residual LSB weight is a quarter of the divisor LSB
  // So X/4 is the dividend zero-extended
  assign wCur  = step.first ? $signed({{(`DIV_RW-`DIV_W){1'b0}}, opReg.dividend}) : residual;
  assign uCur  = step.first ? '0 : u;
  assign umCur = step.first ? '0 : um;
  assign cCur  = step.first ? CInit : cReg;

  assign dExt = $signed({{(`DIV_RW-`DIV_W){1'b0}}, opReg.divisor});

  // Same bits read at divisor weight give 4w
  digitSelect i_digitSelect (
    .residual4 (wCur),
    .divisor   (opReg.divisor),
    .digit     (digit)
  );

  otfConverter i_otfConverter (
    .digit  (digit),
    .u      (uCur),
    .um     (umCur),
    .c      (cCur),
    .uNext  (uNext),
    .umNext (umNext)
  );

  // q times D
  always_comb begin
    if (digit.plus2) begin
      qd = dExt <<< 1;
    end else if (digit.plus1) begin
      qd = dExt;
    end else if (digit.minus1) begin
      qd = -dExt;
    end else if (digit.minus2) begin
      qd = -(dExt <<< 1);
    end else begin
      qd = '0;
    end
  end

  // 4w - qD at divisor weight
  assign stepDiff = wCur - qd;

  //////////////////////////////
  // Step registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (step.active) begin
      // Back to residual weight
      residual <= stepDiff <<< 2;
      u        <= uNext;
      um       <= umNext;
    end
  end

  // Two more mask bits per step
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cReg <= CInit;
    end else if (step.active) begin
      cReg <= {2'b11, cCur[`DIV_QW-1:2]};
    end
  end

  // Residual bound holds while the divisor is held by the sequencer
  assign resMag = residual[`DIV_RW-1] ? -residual : residual;
  assign dBound = dExt <<< 2;

  assert property (@(posedge clk) disable iff (!arstN)
    step.active |=> (resMag <= dBound));

endmodule

/* src/divPkg.sv */
`include "divider_cfg.svh"

package divPkg;

  // Operand pair, both normalized to [1,2)
  typedef struct packed {
    logic [`DIV_W-1:0] dividend;
    logic [`DIV_W-1:0] divisor;
  } divOpT;

  // One-hot quotient digit
  // All flags clear selects digit 0
  typedef struct packed {
    logic plus2;
    logic plus1;
    logic minus1;
    logic minus2;
  } digitT;

  // Step strobes from the sequencer
  typedef struct packed {
    logic active;
    logic first;
    logic last;
  } stepT;

  // Truncated quotient and sticky
  typedef struct packed {
    logic [`DIV_QW-2:0] quotient;
    logic               sticky;
  } divResT;

endpackage

/* src/divResult.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module divResult (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      finish,
  input  logic signed [`DIV_RW-1:0] residual,
  input  logic [`DIV_W-1:0]         divisor,
  input  logic [`DIV_QW-1:0]        u,
  input  logic [`DIV_QW-1:0]        um,
  output divPkg::divResT            result,
  output logic                      done
);

  logic                      negRes;
  logic signed [`DIV_RW-1:0] dAligned;
  logic signed [`DIV_RW-1:0] remFix;
  logic signed [`DIV_RW-1:0] remSel;
  logic [`DIV_QW-1:0]        qSel;
  divPkg::divResT            resNext;

  //////////////////////////////
  // Negative residual fixup
  //////////////////////////////

  assign negRes = residual[`DIV_RW-1];

  // D at residual weight
  assign dAligned = $signed({{(`DIV_RW-`DIV_W-2){1'b0}}, divisor, 2'b00});
  assign remFix   = residual + dAligned;

  // Negative w means U overshot by one unit
  assign qSel   = negRes ? um : u;
  assign remSel = negRes ? remFix : residual;

  always_comb begin
    resNext.quotient = qSel[`DIV_QW-2:0];
    // Any remainder bit left makes the quotient inexact
    resNext.sticky   = |remSel;
  end

  // Result holds until the next finish
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result <= '0;
      done   <= 1'b0;
    end else begin
      done <= finish;
      if (finish) begin
        result <= resNext;
      end
    end
  end

endmodule

/* src/divTop.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module divTop (
  input  logic           clk,
  input  logic           arstN,
  input  logic           start,
  input  divPkg::divOpT  operands,
  output logic           busy,
  output logic           done,
  output divPkg::divResT result
);

  divPkg::divOpT             opReg;
  divPkg::stepT              step;
  logic                      finish;
  logic signed [`DIV_RW-1:0] residual;
  logic [`DIV_QW-1:0]        u;
  logic [`DIV_QW-1:0]        um;

  // Sequencer and operand capture
  divControl i_divControl (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .operands (operands),
    .opReg    (opReg),
    .busy     (busy),
    .step     (step),
    .finish   (finish)
  );

  // One radix-4 step per cycle
  divIteration i_divIteration (
    .clk      (clk),
    .arstN    (arstN),
    .step     (step),
    .opReg    (opReg),
    .residual (residual),
    .u        (u),
    .um       (um)
  );

  // Correction, sticky and done
  divResult i_divResult (
    .clk      (clk),
    .arstN    (arstN),
    .finish   (finish),
    .residual (residual),
    .divisor  (opReg.divisor),
    .u        (u),
    .um       (um),
    .result   (result),
    .done     (done)
  );

endmodule

/* src/divider_cfg.svh */
`ifndef DIVIDER_CFG_SVH
`define DIVIDER_CFG_SVH

// Operand width, integer bit on top
`define DIV_W 16

// Radix-4 recurrence steps per divide
`define DIV_ITER 9

// Width of U, UM and the position mask C
// Two quotient bits per step
`define DIV_QW (2 * `DIV_ITER)

// Signed residual width
// DIV_W+1 fraction bits plus sign and integer headroom
`define DIV_RW (`DIV_W + 4)

`endif

/* src/otfConverter.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module otfConverter (
  input  divPkg::digitT      digit,
  input  logic [`DIV_QW-1:0] u,
  input  logic [`DIV_QW-1:0] um,
  input  logic [`DIV_QW-1:0] c,
  output logic [`DIV_QW-1:0] uNext,
  output logic [`DIV_QW-1:0] umNext
);

  logic [`DIV_QW-1:0] k1;
  logic [`DIV_QW-1:0] k2;
  logic [`DIV_QW-1:0] k3;

  // Lowest mask bit marks the current digit position
  assign k1 = c & ~(c << 1);
  assign k2 = (c << 1) & ~(c << 2);
  assign k3 = c & ~(c << 2);

  // Append the digit by OR only, UM tracks U minus one unit
  always_comb begin
    if (digit.plus2) begin
      uNext  = u | k2;
      umNext = u | k1;
    end else if (digit.plus1) begin
      uNext  = u | k1;
      umNext = u;
    end else if (digit.minus1) begin
      // Borrow taken from UM
      uNext  = um | k3;
      umNext = um | k2;
    end else if (digit.minus2) begin
      uNext  = um | k2;
      umNext = um | k1;
    end else begin
      uNext  = u;
      umNext = um | k3;
    end
  end

endmodule

/* test/divTb.sv */
`timescale 1ns/1ps
`include "divider_cfg.svh"

module divTb;

  localparam int NumRandom = 400;
  // Budget per divide with its mean gap, plus reset and corner cases
  localparam int TimeoutCycles = NumRandom * (`DIV_ITER + 5) + 100;
  localparam logic [`DIV_W-1:0] OneVal = {1'b1, {(`DIV_W-1){1'b0}}};
  localparam logic [`DIV_W-1:0] MaxVal = {`DIV_W{1'b1}};

  logic           clk;
  logic           arstN;
  logic           start;
  divPkg::divOpT  operands;
  logic           busy;
  logic           done;
  divPkg::divResT result;

  integer seed = 32'he1f1;
  int     cycleCnt = 0;
  int     opCount = 0;
  int     doneCount = 0;

  divTop i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .start    (start),
    .operands (operands),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Truncated exact quotient with 2*(ITER-1) fraction bits
  task automatic modelDivide(input logic [`DIV_W-1:0] x, input logic [`DIV_W-1:0] d,
                             output logic [`DIV_QW-2:0] q, output logic sticky);
    logic [63:0] num;
    logic [63:0] quo;
    num    = 64'(x) << (2 * (`DIV_ITER - 1));
    quo    = num / 64'(d);
    q      = quo[`DIV_QW-2:0];
    sticky = (num % 64'(d)) != 64'd0;
  endtask

  // Random value in [1,2)
  function automatic logic [`DIV_W-1:0] randomOperand();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[`DIV_W-1:0] | OneVal;
  endfunction

  // Starts at a falling edge and returns one cycle after done
  task automatic runDivide(input logic [`DIV_W-1:0] x, input logic [`DIV_W-1:0] d,
                           input bit startWhileBusy);
    logic [`DIV_QW-2:0] expQ;
    logic               expSticky;
    int                 edgeNum;
    modelDivide(x, d, expQ, expSticky);
    operands.dividend = x;
    operands.divisor  = d;
    start             = 1'b1;
    opCount++;
    @(negedge clk);
    start   = 1'b0;
    edgeNum = 0;
    while (!done) begin
      assert (busy) else abortRun("busy is low while a divide is in progress");
      // Starts that must be ignored
      // The last one lands on the done edge
      if (startWhileBusy && (edgeNum == 1 || edgeNum == 4 || edgeNum == `DIV_ITER)) begin
        operands.dividend = ~x | OneVal;
        operands.divisor  = ~d | OneVal;
        start             = 1'b1;
      end
      @(negedge clk);
      start = 1'b0;
      edgeNum++;
    end
    assert (edgeNum == `DIV_ITER + 1)
      else abortRun($sformatf("MISMATCH at %0t ns: done after %0d cycles, expected %0d",
                              $time, edgeNum, `DIV_ITER + 1));
    assert (!busy) else abortRun("busy did not fall together with done");
    assert (result.quotient == expQ)
      else abortRun($sformatf("MISMATCH at %0t ns: quotient %h, expected %h for X=%h D=%h",
                              $time, result.quotient, expQ, x, d));
    assert (result.sticky == expSticky)
      else abortRun($sformatf("MISMATCH at %0t ns: sticky %b, expected %b for X=%h D=%h",
                              $time, result.sticky, expSticky, x, d));
    @(negedge clk);
    assert (!done) else abortRun("done stayed high for more than one cycle");
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  always @(negedge clk) begin
    if (arstN && done) begin
      doneCount++;
    end
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= TimeoutCycles) begin
      abortRun("Timeout: the run hung before all divides completed");
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [31:0]       rnd;
    logic [`DIV_W-1:0] x;
    logic [`DIV_W-1:0] d;
    arstN    = 1'b0;
    start    = 1'b0;
    operands = '0;
    repeat (5) begin
      @(negedge clk);
      assert (!busy && !done) else abortRun("busy or done is high during reset");
    end
    arstN = 1'b1;
    @(negedge clk);
    assert (!busy && !done && result == '0)
      else abortRun("outputs are not idle right after reset");

    // Corner operands
    runDivide(OneVal | (MaxVal >> 3), OneVal | (MaxVal >> 3), 1'b0);
    runDivide(MaxVal, OneVal, 1'b0);
    runDivide(OneVal, MaxVal, 1'b0);
    runDivide(OneVal + (MaxVal >> 2) + 1'b1, OneVal + (MaxVal >> 2), 1'b0);

    // Random operands with 0 to 3 idle cycles between divides
    for (int i = 0; i < NumRandom; i++) begin
      rnd = $random(seed);
      repeat (rnd[1:0]) @(negedge clk);
      x = randomOperand();
      d = randomOperand();
      runDivide(x, d, 1'b0);
    end

    // Start pulses during busy must not cause a second done
    x = randomOperand();
    d = randomOperand();
    runDivide(x, d, 1'b1);
    repeat (`DIV_ITER + 2) begin
      @(negedge clk);
      assert (!done && !busy) else abortRun("a start during busy launched another divide");
    end

    if (doneCount == opCount) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abortRun($sformatf("MISMATCH at %0t ns: %0d done pulses for %0d divides",
                         $time, doneCount, opCount));
    end
  end

endmodule
